// ==== design/rv_pkg.sv ====
// rv_pkg: widths, opcodes, ALU codes and record types shared by the rv_core blocks
`default_nettype none

package rv_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int XLEN          = 32;
    localparam int PC_BITS       = 16;
    localparam int REG_ADDR_BITS = 5;
    localparam int INSN_BYTES    = 4;

    // ------------------------------------------------------------------------
    // encodings
    // ------------------------------------------------------------------------
    // major opcodes, bits [6:0] of the word
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // funct3 of OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 variants, ALT selects SUB and SRA
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // ------------------------------------------------------------------------
    // records
    // ------------------------------------------------------------------------
    // wishbone classic read request, master to slave
    typedef struct packed {
        logic               cyc;
        logic               stb;
        logic [PC_BITS-1:0] adr;
    } wb_req_t;

    typedef struct packed {
        logic                     valid;
        logic [PC_BITS-1:0]       pc;
        logic [XLEN-1:0]          ir;
        logic [REG_ADDR_BITS-1:0] rs1;
        logic [REG_ADDR_BITS-1:0] rs2;
        logic [REG_ADDR_BITS-1:0] rd;
        logic                     rd_we;
        logic                     use_imm;
        logic                     use_pc;
        logic                     zero_a;
        logic [XLEN-1:0]          imm;
        alu_op_t                  alu_op;
    } decoded_t;

    // one retired instruction, also the debug view
    typedef struct packed {
        logic                     valid;
        logic [PC_BITS-1:0]       pc;
        logic [XLEN-1:0]          ir;
        logic                     rd_we;
        logic [REG_ADDR_BITS-1:0] rd;
        logic [XLEN-1:0]          value;
    } retire_t;

endpackage

`default_nettype wire

// ==== design/rv_fetch.sv ====
// rv_fetch holds the program counter and runs the wishbone classic instruction read
`timescale 1ns/1ns
`default_nettype none

module rv_fetch (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire                          start_i,
    input  wire  [rv_pkg::PC_BITS-1:0]   start_addr_i,
    input  wire                          retire_i,
    output rv_pkg::wb_req_t              wb_req_o,
    input  wire                          wb_ack_i,
    input  wire  [rv_pkg::XLEN-1:0]      wb_dat_i,
    output logic                         fetch_valid_o,
    output logic [rv_pkg::PC_BITS-1:0]   fetch_pc_o,
    output logic [rv_pkg::XLEN-1:0]      fetch_ir_o
);

    import rv_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT
    } fetch_state_t;

    fetch_state_t       state_q;
    logic [PC_BITS-1:0] pc_q;
    logic               fetch_valid_q;
    logic [XLEN-1:0]    ir_q;
    logic               ack_taken;

    assign ack_taken = (state_q == S_REQ) && wb_ack_i;

    // ------------------------------------------------------------------------
    // control FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q       <= S_IDLE;
            pc_q          <= '0;
            fetch_valid_q <= 1'b0;
        end else begin
            fetch_valid_q <= ack_taken;
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        pc_q    <= start_addr_i;
                        state_q <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (wb_ack_i) begin
                        state_q <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    // one instruction in flight so the next read waits for retire
                    if (retire_i) begin
                        pc_q    <= pc_q + PC_BITS'(INSN_BYTES);
                        state_q <= S_REQ;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // instruction word
    always_ff @(posedge clk) begin
        if (ack_taken) begin
            ir_q <= wb_dat_i;
        end
    end

    always_comb begin
        wb_req_o.cyc = (state_q == S_REQ);
        wb_req_o.stb = (state_q == S_REQ);
        wb_req_o.adr = pc_q;
    end

    assign fetch_valid_o = fetch_valid_q;
    assign fetch_pc_o    = pc_q;
    assign fetch_ir_o    = ir_q;

    // a retire outside S_WAIT would be lost
    a_retire_when_waiting: assert property (@(posedge clk) disable iff (!rst_n_i)
        retire_i |-> (state_q == S_WAIT));

    // request held through slave wait states
    a_adr_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        (wb_req_o.stb && !wb_ack_i) |=> (wb_req_o.stb && $stable(wb_req_o.adr)));

endmodule

`default_nettype wire

// ==== design/rv_decode.sv ====
// rv_decode: latches a fetched word and splits it into a decoded instruction record
`timescale 1ns/1ns
`default_nettype none

module rv_decode (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire                          fetch_valid_i,
    input  wire  [rv_pkg::PC_BITS-1:0]   fetch_pc_i,
    input  wire  [rv_pkg::XLEN-1:0]      fetch_ir_i,
    output rv_pkg::decoded_t             dec_o
);

    import rv_pkg::*;

    logic                     valid_q;
    logic [PC_BITS-1:0]       pc_q;
    logic [XLEN-1:0]          ir_q;
    logic [6:0]               opcode;
    logic [2:0]               funct3;
    logic [6:0]               funct7;
    logic [REG_ADDR_BITS-1:0] rd;
    logic [XLEN-1:0]          imm_i;
    logic [XLEN-1:0]          imm_u;
    logic                     legal;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fetch_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid_i) begin
            pc_q <= fetch_pc_i;
            ir_q <= fetch_ir_i;
        end
    end

    // ------------------------------------------------------------------------
    // field extraction
    // ------------------------------------------------------------------------
    assign opcode = ir_q[6:0];
    assign rd     = ir_q[11:7];
    assign funct3 = ir_q[14:12];
    assign funct7 = ir_q[31:25];
    assign imm_i  = {{(XLEN-12){ir_q[31]}}, ir_q[31:20]};
    assign imm_u  = {ir_q[31:12], 12'b0};

    always_comb begin
        legal         = 1'b0;
        dec_o.valid   = valid_q;
        dec_o.pc      = pc_q;
        dec_o.ir      = ir_q;
        dec_o.rs1     = ir_q[19:15];
        dec_o.rs2     = ir_q[24:20];
        dec_o.rd      = rd;
        dec_o.use_imm = 1'b0;
        dec_o.use_pc  = 1'b0;
        dec_o.zero_a  = 1'b0;
        dec_o.imm     = imm_i;
        dec_o.alu_op  = ALU_ADD;
        case (opcode)
            OPC_OP_IMM: begin
                dec_o.use_imm = 1'b1;
                legal         = 1'b1;
                case (funct3)
                    F3_ADD_SUB: dec_o.alu_op = ALU_ADD;
                    F3_SLL: begin
                        dec_o.alu_op = ALU_SLL;
                        legal        = (funct7 == F7_BASE);
                    end
                    F3_SLT:  dec_o.alu_op = ALU_SLT;
                    F3_SLTU: dec_o.alu_op = ALU_SLTU;
                    F3_XOR:  dec_o.alu_op = ALU_XOR;
                    F3_SRL_SRA: begin
                        dec_o.alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                        legal        = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                    end
                    F3_OR:   dec_o.alu_op = ALU_OR;
                    default: dec_o.alu_op = ALU_AND;
                endcase
            end
            OPC_OP: begin
                case (funct3)
                    F3_ADD_SUB: dec_o.alu_op = (funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     dec_o.alu_op = ALU_SLL;
                    F3_SLT:     dec_o.alu_op = ALU_SLT;
                    F3_SLTU:    dec_o.alu_op = ALU_SLTU;
                    F3_XOR:     dec_o.alu_op = ALU_XOR;
                    F3_SRL_SRA: dec_o.alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                    F3_OR:      dec_o.alu_op = ALU_OR;
                    default:    dec_o.alu_op = ALU_AND;
                endcase
                // alt funct7 only for SUB and SRA, anything else is M or reserved
                legal = (funct7 == F7_BASE) ||
                        ((funct7 == F7_ALT) &&
                         ((funct3 == F3_ADD_SUB) || (funct3 == F3_SRL_SRA)));
            end
            OPC_LUI: begin
                dec_o.zero_a  = 1'b1;
                dec_o.use_imm = 1'b1;
                dec_o.imm     = imm_u;
                legal         = 1'b1;
            end
            OPC_AUIPC: begin
                dec_o.use_pc  = 1'b1;
                dec_o.use_imm = 1'b1;
                dec_o.imm     = imm_u;
                legal         = 1'b1;
            end
            default: legal = 1'b0;
        endcase
        // unsupported words and x0 targets never write
        dec_o.rd_we = legal && (rd != '0);
    end

endmodule

`default_nettype wire

// ==== design/rv_reg_file.sv ====
// rv_reg_file: 32 x 32 integer registers, two read ports and one write port
`timescale 1ns/1ns
`default_nettype none

module rv_reg_file (
    input  wire                                clk,
    input  wire                                rst_n_i,
    input  wire  [rv_pkg::REG_ADDR_BITS-1:0]   rs1_addr_i,
    input  wire  [rv_pkg::REG_ADDR_BITS-1:0]   rs2_addr_i,
    output logic [rv_pkg::XLEN-1:0]            rs1_data_o,
    output logic [rv_pkg::XLEN-1:0]            rs2_data_o,
    input  wire                                we_i,
    input  wire  [rv_pkg::REG_ADDR_BITS-1:0]   waddr_i,
    input  wire  [rv_pkg::XLEN-1:0]            wdata_i
);

    import rv_pkg::*;

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // ------------------------------------------------------------------------
    // read ports
    // ------------------------------------------------------------------------
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

    // decode filters x0 targets before they reach the write port
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        we_i |-> (waddr_i != '0));

endmodule

`default_nettype wire

// ==== design/rv_execute.sv ====
// rv_execute selects operands and runs the ALU, registering the retire record and register write
`timescale 1ns/1ns
`default_nettype none

module rv_execute (
    input  wire                                clk,
    input  wire                                rst_n_i,
    input  wire  rv_pkg::decoded_t             dec_i,
    input  wire  [rv_pkg::XLEN-1:0]            rs1_data_i,
    input  wire  [rv_pkg::XLEN-1:0]            rs2_data_i,
    output rv_pkg::retire_t                    retire_o,
    output logic                               rf_we_o,
    output logic [rv_pkg::REG_ADDR_BITS-1:0]   rf_waddr_o,
    output logic [rv_pkg::XLEN-1:0]            rf_wdata_o
);

    import rv_pkg::*;

    logic [XLEN-1:0]          op_a;
    logic [XLEN-1:0]          op_b;
    logic [4:0]               shamt;
    logic [XLEN-1:0]          alu_res;
    logic                     valid_q;
    logic                     rd_we_q;
    logic [PC_BITS-1:0]       pc_q;
    logic [XLEN-1:0]          ir_q;
    logic [REG_ADDR_BITS-1:0] rd_q;
    logic [XLEN-1:0]          value_q;

    // ------------------------------------------------------------------------
    // operands
    // ------------------------------------------------------------------------
    // zero_a selects zero for LUI and use_pc the pc for AUIPC
    assign op_a = dec_i.zero_a ? '0 :
                  dec_i.use_pc ? {{(XLEN-PC_BITS){1'b0}}, dec_i.pc} : rs1_data_i;
    assign op_b  = dec_i.use_imm ? dec_i.imm : rs2_data_i;
    assign shamt = op_b[4:0];

    // ------------------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------------------
    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << shamt;
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> shamt;
            ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            default:  alu_res = op_a + op_b;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            rd_we_q <= 1'b0;
        end else begin
            valid_q <= dec_i.valid;
            rd_we_q <= dec_i.valid && dec_i.rd_we;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_i.valid) begin
            pc_q    <= dec_i.pc;
            ir_q    <= dec_i.ir;
            rd_q    <= dec_i.rd;
            value_q <= alu_res;
        end
    end

    always_comb begin
        retire_o.valid = valid_q;
        retire_o.pc    = pc_q;
        retire_o.ir    = ir_q;
        retire_o.rd_we = rd_we_q;
        retire_o.rd    = rd_q;
        retire_o.value = value_q;
    end

    // write port mirrors the retire record
    assign rf_we_o    = rd_we_q;
    assign rf_waddr_o = rd_q;
    assign rf_wdata_o = value_q;

    // one instruction in flight, no new decode while one retires
    a_one_in_flight: assert property (@(posedge clk) disable iff (!rst_n_i)
        retire_o.valid |-> !dec_i.valid);

endmodule

`default_nettype wire

// ==== design/rv_core.sv ====
// rv_core: multi-cycle RV32I integer core with wishbone instruction fetch
`timescale 1ns/1ns
`default_nettype none

module rv_core (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire                          start_i,
    input  wire  [rv_pkg::PC_BITS-1:0]   start_addr_i,
    output rv_pkg::wb_req_t              wb_req_o,
    input  wire                          wb_ack_i,
    input  wire  [rv_pkg::XLEN-1:0]      wb_dat_i,
    output rv_pkg::retire_t              retire_o
);

    import rv_pkg::*;

    logic                     fetch_valid;
    logic [PC_BITS-1:0]       fetch_pc;
    logic [XLEN-1:0]          fetch_ir;
    decoded_t                 dec;
    logic [XLEN-1:0]          rs1_data;
    logic [XLEN-1:0]          rs2_data;
    logic                     rf_we;
    logic [REG_ADDR_BITS-1:0] rf_waddr;
    logic [XLEN-1:0]          rf_wdata;

    // ------------------------------------------------------------------------
    // fetch side, restarted by each retire
    // ------------------------------------------------------------------------
    rv_fetch u_fetch (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .start_i       (start_i),
        .start_addr_i  (start_addr_i),
        .retire_i      (retire_o.valid),
        .wb_req_o      (wb_req_o),
        .wb_ack_i      (wb_ack_i),
        .wb_dat_i      (wb_dat_i),
        .fetch_valid_o (fetch_valid),
        .fetch_pc_o    (fetch_pc),
        .fetch_ir_o    (fetch_ir)
    );

    rv_decode u_decode (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .fetch_valid_i (fetch_valid),
        .fetch_pc_i    (fetch_pc),
        .fetch_ir_i    (fetch_ir),
        .dec_o         (dec)
    );

    rv_reg_file u_reg_file (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (dec.rs1),
        .rs2_addr_i (dec.rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rf_we),
        .waddr_i    (rf_waddr),
        .wdata_i    (rf_wdata)
    );

    rv_execute u_execute (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .dec_i      (dec),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .retire_o   (retire_o),
        .rf_we_o    (rf_we),
        .rf_waddr_o (rf_waddr),
        .rf_wdata_o (rf_wdata)
    );

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
// tb_clock_gen: free-running testbench clock and power-on reset for rv_core
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tests/tb_core.sv ====
// tb_core testbench for rv_core with wishbone instruction memory, random program and reference model
`timescale 1ns/1ns
`default_nettype none

module tb_core;

    import rv_pkg::*;

    localparam int N_INSN       = 200;
    localparam int RESET_CYCLES = 16;
    localparam int CLK_PERIOD   = 10;
    localparam int MAX_WAIT     = 3;
    // fetch, decode, execute, worst wait states and the restart cycle
    localparam int CYCLES_PER_INSN = 3 + 1 + MAX_WAIT + 1;
    localparam int WATCHDOG_NS =
        2 * (N_INSN * CYCLES_PER_INSN + RESET_CYCLES + 8) * CLK_PERIOD;
    localparam logic [31:0] SEED = 32'h41d78329;

    typedef struct packed {
        logic                     we;
        logic [REG_ADDR_BITS-1:0] rd;
        logic [XLEN-1:0]          value;
    } expect_t;

    logic               clk;
    logic               rst_n;
    logic               start;
    logic [PC_BITS-1:0] start_addr;
    wb_req_t            wb_req;
    logic               wb_ack;
    logic [XLEN-1:0]    wb_dat;
    retire_t            retire;

    logic [XLEN-1:0]    prog [N_INSN];
    logic [PC_BITS-1:0] fetch_adr [N_INSN];
    logic [PC_BITS-1:0] prog_base;
    int                 fetch_count;
    int                 retire_count;

    tb_clock_gen u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    rv_core u_dut (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .start_i      (start),
        .start_addr_i (start_addr),
        .wb_req_o     (wb_req),
        .wb_ack_i     (wb_ack),
        .wb_dat_i     (wb_dat),
        .retire_o     (retire)
    );

    task automatic report_mismatch(input string what);
        $display("MISMATCH at %0t ns: %s", $time, what);
        $display("Verification failed");
        $fatal(1, "run stopped at the first error");
    endtask

    // ------------------------------------------------------------------------
    // program generation
    // ------------------------------------------------------------------------
    // small register window so results feed later instructions
    function automatic logic [REG_ADDR_BITS-1:0] pick_reg();
        return REG_ADDR_BITS'($urandom % 8);
    endfunction

    function automatic logic [XLEN-1:0] make_insn(input int idx);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        int          kind;
        r  = $urandom;
        f3 = r[14:12];
        // seed x1..x7 with wide values first
        if (idx < 7) begin
            return {r[31:12], 5'(idx + 1), OPC_LUI};
        end
        kind = int'($urandom % 100);
        if (kind < 10) begin
            case ($urandom % 6)
                0:       return {r[31:7], 7'b0000011};
                1:       return {r[31:7], 7'b0100011};
                2:       return {r[31:7], 7'b1100011};
                3:       return {r[31:7], 7'b1101111};
                4:       return {r[31:7], 7'b1110011};
                // multiply group is not supported
                default: return {7'b0000001, pick_reg(), pick_reg(), f3, pick_reg(), OPC_OP};
            endcase
        end
        if (kind < 40) begin
            imm = r[31:20];
            if (f3 == 3'b001) begin
                imm = {7'b0000000, r[24:20]};
            end else if (f3 == 3'b101) begin
                imm = {(r[30] ? 7'b0100000 : 7'b0000000), r[24:20]};
            end
            return {imm, pick_reg(), f3, pick_reg(), OPC_OP_IMM};
        end
        if (kind < 75) begin
            f7 = ((f3 == 3'b000 || f3 == 3'b101) && r[30]) ? 7'b0100000 : 7'b0000000;
            return {f7, pick_reg(), pick_reg(), f3, pick_reg(), OPC_OP};
        end
        if (kind < 88) begin
            return {r[31:12], pick_reg(), OPC_LUI};
        end
        return {r[31:12], pick_reg(), OPC_AUIPC};
    endfunction

    function automatic logic [XLEN-1:0] read_word(input logic [PC_BITS-1:0] adr);
        logic [PC_BITS-1:0] offset;
        int                 idx;
        offset = adr - prog_base;
        idx    = int'(offset >> 2);
        if (offset[1:0] == 2'b00 && idx < N_INSN) begin
            return prog[idx];
        end
        // outside the program
        return {adr, ~adr};
    endfunction

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    function automatic expect_t predict_retire(
        input logic [PC_BITS-1:0] pc,
        input logic [XLEN-1:0]    ir,
        input logic [XLEN-1:0]    regs [32]
    );
        expect_t                res;
        logic [6:0]             opc;
        logic [2:0]             f3;
        logic [6:0]             f7;
        logic [XLEN-1:0]        a;
        logic [XLEN-1:0]        b;
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic [4:0]             sh;
        logic                   legal;
        opc       = ir[6:0];
        f3        = ir[14:12];
        f7        = ir[31:25];
        a         = regs[ir[19:15]];
        legal     = 1'b0;
        res.rd    = ir[11:7];
        res.value = '0;
        // register-immediate forms use the sign-extended I immediate
        if (opc == OPC_OP_IMM) begin
            b = {{20{ir[31]}}, ir[31:20]};
        end else begin
            b = regs[ir[24:20]];
        end
        sa = a;
        sb = b;
        sh = b[4:0];
        if (opc == OPC_OP_IMM || opc == OPC_OP) begin
            case (f3)
                3'b000: res.value = (opc == OPC_OP && f7 == 7'b0100000) ? a - b : a + b;
                3'b001: res.value = a << sh;
                3'b010: res.value = (sa < sb) ? 32'd1 : 32'd0;
                3'b011: res.value = (a < b) ? 32'd1 : 32'd0;
                3'b100: res.value = a ^ b;
                3'b101: begin
                    if (f7 == 7'b0100000) begin
                        res.value = sa >>> sh;
                    end else begin
                        res.value = a >> sh;
                    end
                end
                3'b110: res.value = a | b;
                default: res.value = a & b;
            endcase
            if (opc == OPC_OP_IMM) begin
                legal = (f3 == 3'b001) ? (f7 == 7'b0000000) :
                        (f3 == 3'b101) ? (f7 == 7'b0000000 || f7 == 7'b0100000) : 1'b1;
            end else begin
                legal = (f7 == 7'b0000000) ||
                        (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101));
            end
        end else if (opc == OPC_LUI) begin
            legal     = 1'b1;
            res.value = {ir[31:12], 12'b0};
        end else if (opc == OPC_AUIPC) begin
            legal     = 1'b1;
            res.value = {{(XLEN-PC_BITS){1'b0}}, pc} + {ir[31:12], 12'b0};
        end
        res.we = legal && (res.rd != 5'd0);
        return res;
    endfunction

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    initial begin : stimulus
        int start_word;
        void'($urandom(SEED));
        start      = 1'b0;
        start_addr = '0;
        start_word = int'($urandom % (2 ** (PC_BITS - 2) - N_INSN - 8));
        prog_base  = 16'(start_word * 4);
        for (int i = 0; i < N_INSN; i++) begin
            prog[i] = make_insn(i);
        end
        // quiet through reset and a few cycles after it
        repeat (RESET_CYCLES + 4) begin
            @(negedge clk);
            assert (!wb_req.cyc && !wb_req.stb && !retire.valid)
                else report_mismatch("bus or retire active before start");
        end
        start      = 1'b1;
        start_addr = prog_base;
        @(negedge clk);
        start = 1'b0;
        wait (retire_count == N_INSN);
        @(negedge clk);
        $display("Verification passed");
        $finish;
    end

    // wishbone slave with 0 to 3 wait states per read
    initial begin : wb_memory
        int                 wait_left;
        logic [PC_BITS-1:0] exp_adr;
        wb_ack      = 1'b0;
        wb_dat      = '0;
        fetch_count = 0;
        wait_left   = -1;
        forever begin
            @(negedge clk);
            if (wb_ack) begin
                // master drops the request in the cycle after the ack edge
                assert (!wb_req.cyc && !wb_req.stb)
                    else report_mismatch("bus request still active after ack");
                wb_ack    = 1'b0;
                wait_left = -1;
            end else if (wb_req.cyc && wb_req.stb) begin
                if (wait_left < 0) begin
                    wait_left = int'($urandom % (MAX_WAIT + 1));
                end
                if (wait_left == 0) begin
                    exp_adr = prog_base + 16'(4 * fetch_count);
                    assert (wb_req.adr == exp_adr)
                        else report_mismatch($sformatf("fetch adr %h, expected %h",
                                                       wb_req.adr, exp_adr));
                    if (fetch_count < N_INSN) begin
                        fetch_adr[fetch_count] = wb_req.adr;
                    end
                    wb_dat      = read_word(wb_req.adr);
                    wb_ack      = 1'b1;
                    fetch_count = fetch_count + 1;
                end else begin
                    wait_left = wait_left - 1;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // retire comparison
    // ------------------------------------------------------------------------
    initial begin : compare
        logic [XLEN-1:0]    model_regs [32];
        expect_t            exp;
        logic [PC_BITS-1:0] exp_pc;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        retire_count = 0;
        forever begin
            @(negedge clk);
            if (rst_n && retire.valid && retire_count < N_INSN) begin
                exp_pc = prog_base + 16'(4 * retire_count);
                exp    = predict_retire(exp_pc, prog[retire_count], model_regs);
                assert (retire_count < fetch_count)
                    else report_mismatch("retire without a preceding fetch");
                assert (retire.pc == exp_pc)
                    else report_mismatch($sformatf("retire %0d pc %h, expected %h",
                                                   retire_count, retire.pc, exp_pc));
                assert (retire.pc == fetch_adr[retire_count])
                    else report_mismatch($sformatf("retire %0d pc %h, fetched from %h",
                                                   retire_count, retire.pc,
                                                   fetch_adr[retire_count]));
                assert (retire.ir == prog[retire_count])
                    else report_mismatch($sformatf("retire %0d ir %h, expected %h",
                                                   retire_count, retire.ir,
                                                   prog[retire_count]));
                assert (retire.rd_we == exp.we)
                    else report_mismatch($sformatf("ir %h rd_we %b, expected %b",
                                                   retire.ir, retire.rd_we, exp.we));
                assert (retire.rd == exp.rd)
                    else report_mismatch($sformatf("ir %h rd %0d, expected %0d",
                                                   retire.ir, retire.rd, exp.rd));
                if (exp.we) begin
                    assert (retire.value == exp.value)
                        else report_mismatch($sformatf("ir %h value %h, expected %h",
                                                       retire.ir, retire.value, exp.value));
                    model_regs[exp.rd] = exp.value;
                end
                retire_count = retire_count + 1;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with %0d of %0d instructions retired",
                 WATCHDOG_NS, retire_count, N_INSN);
        $display("Verification failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// ==== list.f ====
design/rv_pkg.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_reg_file.sv
design/rv_execute.sv
design/rv_core.sv
tests/tb_clock_gen.sv
tests/tb_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_core
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_core)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

printf '%s\n' "$out" | grep -qx "Verification passed" || exit 1
exit 0
